// ==== verilog.f ====
+incdir+verilog
+incdir+sim
verilog/motor_pkg.sv
verilog/step_tick_gen.sv
verilog/speed_ramp_ram.sv
verilog/step_motor_axis.sv
verilog/motor_wb_regs.sv
verilog/motor_ctrl_top.sv
sim/tb_motor_ctrl.sv

// ==== Makefile ====
# Verilator flow for the stepper motor controller
# override on the command line, e.g. make sim SEED=7

VERILATOR ?= verilator
TOP       ?= tb_motor_ctrl
RTL_TOP   ?= motor_ctrl_top
FILELIST  ?= verilog.f
SEED      ?= 1
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# the testbench ends in $$fatal on any failure, so the run's exit status is the verdict
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED)

clean:
	rm -rf $(BUILD_DIR)

// ==== sim/tb_motor_tasks.svh ====
`ifndef TB_MOTOR_TASKS_SVH
`define TB_MOTOR_TASKS_SVH

task automatic abort_run();
	$display("Simulation finished: FAIL");
	$fatal(1, "stopping at the first error");
endtask

task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp) begin
		$display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
		abort_run();
	end
endtask

task automatic next_cycle();
	@(posedge clk);
	#1;
endtask

task automatic wb_access(input logic we, input logic [`MOTOR_WB_AW-1:0] adr,
		input logic [31:0] wdat, output logic [31:0] rdat);
	int n;
	n = 0;
	wb_cyc = 1'b1;
	wb_stb = 1'b1;
	wb_we = we;
	wb_adr = adr;
	wb_dat_w = wdat;
	do begin
		next_cycle();
		n++;
		if (n > ACK_LIMIT) begin
			$display("no Wishbone ack for address 0x%03h", adr);
			abort_run();
		end
	end while (!wb_ack);
	rdat = wb_dat_r;
	wb_cyc = 1'b0;
	wb_stb = 1'b0;
	wb_we = 1'b0;
endtask

task automatic wb_write(input logic [`MOTOR_WB_AW-1:0] adr, input logic [31:0] dat);
	logic [31:0] unused;
	wb_access(1'b1, adr, dat, unused);
endtask

task automatic wb_read(input logic [`MOTOR_WB_AW-1:0] adr, output logic [31:0] dat);
	wb_access(1'b0, adr, 32'd0, dat);
endtask

function automatic logic [31:0] ctrl_word(input logic start, input logic stop,
		input logic d, input logic [`MOTOR_MS_W-1:0] m, input logic en, input logic rst);
	logic [31:0] w;
	w = '0;
	w[`CTRL_START] = start;
	w[`CTRL_STOP] = stop;
	w[`CTRL_DIR] = d;
	w[`CTRL_MS_LSB +: `MOTOR_MS_W] = m;
	w[`CTRL_XEN] = en;
	w[`CTRL_XRST] = rst;
	return w;
endfunction

task automatic start_move(input int steps, input logic d, input logic [`MOTOR_MS_W-1:0] m);
	wb_write(`REG_STEPS, steps);
	wb_write(`REG_CTRL, ctrl_word(1'b1, 1'b0, d, m, 1'b1, 1'b0));
endtask

task automatic wait_for_busy();
	logic [31:0] st;
	int n;
	n = 0;
	do begin
		wb_read(`REG_STATUS, st);
		n++;
		if (n > POLL_LIMIT) begin
			$display("motor never reported busy after start");
			abort_run();
		end
	end while (!st[`STATUS_BUSY]);
endtask

// counts rising drive edges since base until busy drops
task automatic count_pulses(input int base, output int pulses);
	logic [31:0] st;
	int last;
	int idle;
	last = rise_cnt;
	idle = 0;
	wb_read(`REG_STATUS, st);
	while (st[`STATUS_BUSY]) begin
		if (rise_cnt != last) begin
			last = rise_cnt;
			idle = 0;
		end else begin
			idle++;
		end
		if (idle > IDLE_LIMIT) begin
			$display("motor stays busy without any drive pulses");
			abort_run();
		end
		wb_read(`REG_STATUS, st);
	end
	pulses = rise_cnt - base;
endtask

task automatic wait_for_edges(input logic rising, input int target);
	int n;
	n = 0;
	while ((rising ? rise_cnt : fall_cnt) < target) begin
		next_cycle();
		n++;
		if (n > EDGE_LIMIT) begin
			$display("timeout waiting for drive edge number %0d", target);
			abort_run();
		end
	end
endtask

// constant tables or values falling with the index
task automatic load_tables(input logic ramp);
	int i;
	for (i = 0; i < TBL_LEN; i++) begin
		if (!ramp) begin
			acc_ref[i] = 16'd3;
			dec_ref[i] = 16'd3;
		end else if (i == 0) begin
			acc_ref[i] = 16'(80 + $urandom % 20);
			dec_ref[i] = 16'(80 + $urandom % 20);
		end else begin
			acc_ref[i] = acc_ref[i - 1] - 16'($urandom % 4 + 1);
			dec_ref[i] = dec_ref[i - 1] - 16'($urandom % 4 + 1);
		end
		wb_write(12'(`RAMP_BASE_ACC + i), {16'd0, acc_ref[i]});
		wb_write(12'(`RAMP_BASE_DEC + i), {16'd0, dec_ref[i]});
	end
endtask

function automatic logic [`MOTOR_SPEED_W-1:0] expected_speed(input int k, input int n,
		input int m, input logic [`MOTOR_SPEED_W-1:0] spd);
	int ai;
	int di;
	logic [`MOTOR_SPEED_W-1:0] best;
	// full steps done held at the limit
	ai = k >> m;
	if (ai > ACC_MAX)
		ai = ACC_MAX;
	// remaining count is zero on the last pulse
	di = (n - 1 - k) >> m;
	if (di > DEC_MAX)
		di = DEC_MAX;
	best = spd;
	if (acc_ref[ai] > best)
		best = acc_ref[ai];
	if (dec_ref[di] > best)
		best = dec_ref[di];
	return best;
endfunction

task automatic test_register_access();
	logic [31:0] st;
	wb_write(`REG_SPEED, BASE_SPEED);
	wb_write(`REG_STEPS, COUNT_STEPS);
	wb_write(`REG_STROKE, 32'd1000);
	wb_write(`REG_LIMITS, (32'(DEC_MAX) << `LIMITS_DEAC_LSB) | 32'(ACC_MAX));
	wb_read(`REG_STATUS, st);
	check("busy after reset", 32'(st[`STATUS_BUSY]), 32'd0);
	wb_write(`REG_CTRL, ctrl_word(1'b0, 1'b0, 1'b0, 3'd0, 1'b1, 1'b1));
	check("xen set", 32'(xen), 32'd1);
	check("xrst set", 32'(xrst), 32'd1);
	wb_write(`REG_CTRL, ctrl_word(1'b0, 1'b0, 1'b0, 3'd0, 1'b1, 1'b0));
	check("xen held", 32'(xen), 32'd1);
	check("xrst cleared", 32'(xrst), 32'd0);
endtask

task automatic test_step_count();
	int base;
	int pulses;
	load_tables(1'b0);
	wb_write(`REG_SPEED, BASE_SPEED);
	base = rise_cnt;
	start_move(COUNT_STEPS, 1'b0, COUNT_MS);
	wait_for_busy();
	check("dir on forward move", 32'(dir), 32'd0);
	check("microstep output", 32'(ms), 32'(COUNT_MS));
	count_pulses(base, pulses);
	check("drive pulses", pulses, COUNT_STEPS);
endtask

task automatic test_ramp_speed();
	logic [31:0] st;
	int base;
	int fbase;
	int pulses;
	int k;
	load_tables(1'b1);
	wb_write(`REG_SPEED, RAMP_SPEED);
	base = rise_cnt;
	fbase = fall_cnt;
	start_move(RAMP_STEPS, 1'b0, 3'(RAMP_MS));
	wait_for_busy();
	for (k = 1; k < RAMP_STEPS; k++) begin
		wait_for_edges(1'b0, fbase + k);
		// edge is seen one cycle late and the refresh lands six cycles after it
		repeat (5) next_cycle();
		wb_read(`REG_STATUS, st);
		check("ramp speed", 32'(st[`STATUS_SPEED_LSB +: `MOTOR_SPEED_W]),
			32'(expected_speed(k, RAMP_STEPS, RAMP_MS, 16'(RAMP_SPEED))));
	end
	count_pulses(base, pulses);
	check("ramp move pulses", pulses, RAMP_STEPS);
endtask

task automatic test_stop();
	int base;
	int pulses;
	wb_write(`REG_SPEED, BASE_SPEED);
	base = rise_cnt;
	start_move(STOP_STEPS, 1'b0, 3'd0);
	wait_for_busy();
	wait_for_edges(1'b1, base + 5);
	wb_write(`REG_CTRL, ctrl_word(1'b0, 1'b1, 1'b0, 3'd0, 1'b1, 1'b0));
	count_pulses(base, pulses);
	check("move cut short", 32'(pulses < STOP_STEPS), 32'd1);
	// idle motor stays quiet
	repeat (QUIET_CYCLES) next_cycle();
	check("pulses after stop", rise_cnt - base, pulses);
endtask

task automatic test_reversal();
	int base;
	int pulses;
	int n;
	base = rise_cnt;
	n = 0;
	start_move(REV_STEPS, 1'b1, 3'd0);
	while (dir !== 1'b1) begin
		next_cycle();
		n++;
		if (n > DIR_LIMIT) begin
			$display("direction output never switched for the backward move");
			abort_run();
		end
	end
	check("pulses before direction change", rise_cnt - base, 32'd0);
	check("drive at direction change", 32'(drive), 32'd0);
	count_pulses(base, pulses);
	check("backward move pulses", pulses, REV_STEPS);
endtask

task automatic test_stroke_limit();
	logic [31:0] st;
	int base;
	int pulses;
	int start_pos;
	wb_write(`REG_STROKE, STROKE_LEN);
	// back to the zero sensor first
	start_pos = stub_pos;
	base = rise_cnt;
	start_move(LONG_STEPS, 1'b1, 3'd0);
	wait_for_busy();
	count_pulses(base, pulses);
	check("pulses back to zero", pulses, start_pos);
	wb_read(`REG_STATUS, st);
	check("zpsign at zero", 32'(st[`STATUS_ZPSIGN]), 32'd1);
	base = rise_cnt;
	start_move(LONG_STEPS, 1'b0, 3'd0);
	wait_for_busy();
	count_pulses(base, pulses);
	check("pulses to stroke end", pulses, STROKE_LEN - 1);
	wb_read(`REG_STATUS, st);
	check("tpsign at stroke end", 32'(st[`STATUS_TPSIGN]), 32'd1);
endtask

`endif

// ==== sim/tb_motor_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "motor_cfg.svh"

module tb_motor_ctrl;
	localparam int HALF_PERIOD = 5;
	localparam int TBL_LEN = 16;
	localparam int ACC_MAX = 12;
	localparam int DEC_MAX = 15;
	localparam int BASE_SPEED = 20;
	localparam int COUNT_STEPS = 10;
	localparam logic [`MOTOR_MS_W-1:0] COUNT_MS = 3'd2;
	localparam int RAMP_STEPS = 40;
	localparam int RAMP_MS = 1;
	localparam int RAMP_SPEED = 30;
	localparam int STOP_STEPS = 30;
	localparam int REV_STEPS = 4;
	localparam int STROKE_LEN = 12;
	localparam int LONG_STEPS = 200;
	localparam int ACK_LIMIT = 16;
	localparam int POLL_LIMIT = 100;
	localparam int IDLE_LIMIT = 1000;
	localparam int EDGE_LIMIT = 3000;
	localparam int DIR_LIMIT = 100;
	localparam int QUIET_CYCLES = 1000;

	logic clk = 1'b0;
	logic resetn;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [`MOTOR_WB_AW-1:0] wb_adr;
	logic [`MOTOR_WB_DW-1:0] wb_dat_w;
	wire [`MOTOR_WB_DW-1:0] wb_dat_r;
	wire wb_ack;
	wire zpd;
	wire drive;
	wire dir;
	wire [`MOTOR_MS_W-1:0] ms;
	wire xen;
	wire xrst;

	// motor model position, 0 is the zero sensor
	int stub_pos = 0;
	logic stub_drive_q = 1'b0;
	int rise_cnt = 0;
	int fall_cnt = 0;
	logic mon_drive_q = 1'b0;

	// host copies of the loaded tables
	logic [`MOTOR_SPEED_W-1:0] acc_ref [TBL_LEN];
	logic [`MOTOR_SPEED_W-1:0] dec_ref [TBL_LEN];

	always #HALF_PERIOD clk = ~clk;

	motor_ctrl_top UUT (
		.clk      (clk),
		.resetn   (resetn),
		.i_wb_cyc (wb_cyc),
		.i_wb_stb (wb_stb),
		.i_wb_we  (wb_we),
		.i_wb_adr (wb_adr),
		.i_wb_dat (wb_dat_w),
		.o_wb_dat (wb_dat_r),
		.o_wb_ack (wb_ack),
		.i_zpd    (zpd),
		.o_drive  (drive),
		.o_dir    (dir),
		.o_ms     (ms),
		.o_xen    (xen),
		.o_xrst   (xrst)
	);

	// one position step per falling drive edge
	always @(posedge clk) begin
		#1;
		if (stub_drive_q && !drive) begin
			if (!dir)
				stub_pos = stub_pos + 1;
			else if (stub_pos > 0)
				stub_pos = stub_pos - 1;
		end
		stub_drive_q = drive;
	end

	assign zpd = (stub_pos == 0);

	// drive edge counters, sampled mid-cycle
	always @(negedge clk) begin
		if (drive && !mon_drive_q)
			rise_cnt <= rise_cnt + 1;
		if (!drive && mon_drive_q)
			fall_cnt <= fall_cnt + 1;
		mon_drive_q <= drive;
	end

	`include "tb_motor_tasks.svh"

	initial begin
		resetn = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		void'($urandom(32'h3a7ab06c));
		repeat (3) @(posedge clk);
		#1;
		resetn = 1'b1;
		check("drive after reset", 32'(drive), 32'd0);
		check("ack after reset", 32'(wb_ack), 32'd0);
		check("xen after reset", 32'(xen), 32'd0);
		check("xrst after reset", 32'(xrst), 32'd0);

		test_register_access();
		test_step_count();
		test_ramp_speed();
		test_stop();
		test_reversal();
		test_stroke_limit();

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/motor_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "motor_cfg.svh"

module motor_ctrl_top import motor_pkg::*; (
	input  wire                      clk,
	input  wire                      resetn,
	input  wire                      i_wb_cyc,
	input  wire                      i_wb_stb,
	input  wire                      i_wb_we,
	input  wire [`MOTOR_WB_AW-1:0]   i_wb_adr,
	input  wire [`MOTOR_WB_DW-1:0]   i_wb_dat,
	output wire [`MOTOR_WB_DW-1:0]   o_wb_dat,
	output wire                      o_wb_ack,
	input  wire                      i_zpd,
	output wire                      o_drive,
	output wire                      o_dir,
	output wire [`MOTOR_MS_W-1:0]    o_ms,
	output wire                      o_xen,
	output wire                      o_xrst
);
	logic tick, start, stop;
	motor_cmd_t cmd;
	motor_status_t status;
	ramp_wr_t ramp_wr;
	ramp_rd_t ramp_rd;
	logic [`MOTOR_SPEED_W-1:0] acce_data;
	logic [`MOTOR_SPEED_W-1:0] deac_data;

	step_tick_gen u_tick (
		.clk    (clk),
		.resetn (resetn),
		.o_tick (tick)
	);

	motor_wb_regs u_regs (
		.clk       (clk),
		.resetn    (resetn),
		.i_wb_cyc  (i_wb_cyc),
		.i_wb_stb  (i_wb_stb),
		.i_wb_we   (i_wb_we),
		.i_wb_adr  (i_wb_adr),
		.i_wb_dat  (i_wb_dat),
		.o_wb_dat  (o_wb_dat),
		.o_wb_ack  (o_wb_ack),
		.i_status  (status),
		.o_cmd     (cmd),
		.o_start   (start),
		.o_stop    (stop),
		.o_ramp_wr (ramp_wr)
	);

	speed_ramp_ram u_ramp (
		.clk         (clk),
		.i_wr        (ramp_wr),
		.i_rd        (ramp_rd),
		.o_acce_data (acce_data),
		.o_deac_data (deac_data)
	);

	step_motor_axis u_axis (
		.clk         (clk),
		.resetn      (resetn),
		.i_tick      (tick),
		.i_cmd       (cmd),
		.i_start     (start),
		.i_stop      (stop),
		.i_zpd       (i_zpd),
		.i_acce_data (acce_data),
		.i_deac_data (deac_data),
		.o_rd        (ramp_rd),
		.o_status    (status),
		.o_drive     (o_drive),
		.o_dir       (o_dir),
		.o_ms        (o_ms),
		.o_xen       (o_xen),
		.o_xrst      (o_xrst)
	);

endmodule

`default_nettype wire

// ==== verilog/motor_wb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "motor_cfg.svh"

module motor_wb_regs import motor_pkg::*; (
	input  wire                      clk,
	input  wire                      resetn,
	input  wire                      i_wb_cyc,
	input  wire                      i_wb_stb,
	input  wire                      i_wb_we,
	input  wire [`MOTOR_WB_AW-1:0]   i_wb_adr,
	input  wire [`MOTOR_WB_DW-1:0]   i_wb_dat,
	output logic [`MOTOR_WB_DW-1:0]  o_wb_dat,
	output logic                     o_wb_ack,
	input  wire motor_status_t       i_status,
	output motor_cmd_t               o_cmd,
	output logic                     o_start,
	output logic                     o_stop,
	output ramp_wr_t                 o_ramp_wr
);
	localparam int WAW = `MOTOR_WB_AW;
	localparam int DW = `MOTOR_WB_DW;
	localparam int AW = `MOTOR_RAMP_AW;
	localparam int VW = `MOTOR_SPEED_W;
	localparam int SW = `MOTOR_STEP_W;
	localparam int MW = `MOTOR_MS_W;
	localparam logic [WAW-1:0] ACC_BASE = `RAMP_BASE_ACC;
	localparam logic [WAW-1:0] DEC_BASE = `RAMP_BASE_DEC;

	logic req, wr, reg_hit, acc_hit, dec_hit, ctrl_wr;
	wb_reg_e reg_sel;
	logic [DW-1:0] rd_data;

	// no wait states, ack follows every new request
	assign req = i_wb_cyc && i_wb_stb && !o_wb_ack;
	assign wr = req && i_wb_we;
	assign reg_sel = wb_reg_e'(i_wb_adr[2:0]);
	assign reg_hit = (i_wb_adr[WAW-1:3] == '0);
	assign acc_hit = (i_wb_adr[WAW-1:AW] == ACC_BASE[WAW-1:AW]);
	assign dec_hit = (i_wb_adr[WAW-1:AW] == DEC_BASE[WAW-1:AW]);
	assign ctrl_wr = wr && reg_hit && (reg_sel == WB_CTRL);

	// only status is readable
	always_comb begin
		rd_data = '0;
		if (reg_hit && reg_sel == WB_STATUS) begin
			rd_data[`STATUS_BUSY] = i_status.busy;
			rd_data[`STATUS_ZPSIGN] = i_status.zpsign;
			rd_data[`STATUS_TPSIGN] = i_status.tpsign;
			rd_data[`STATUS_SPEED_LSB +: VW] = i_status.speed;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_wb_ack <= 1'b0;
			o_start <= 1'b0;
			o_stop <= 1'b0;
			o_ramp_wr.en <= 1'b0;
			o_cmd <= '0;
		end else begin
			o_wb_ack <= req;
			// start and stop are strobes, never stored
			o_start <= ctrl_wr && i_wb_dat[`CTRL_START];
			o_stop <= ctrl_wr && i_wb_dat[`CTRL_STOP];
			o_ramp_wr.en <= wr && (acc_hit || dec_hit);
			o_ramp_wr.sel <= dec_hit;
			o_ramp_wr.addr <= i_wb_adr[AW-1:0];
			o_ramp_wr.data <= i_wb_dat[VW-1:0];
			if (wr && reg_hit) begin
				case (reg_sel)
					WB_CTRL: begin
						o_cmd.dir <= i_wb_dat[`CTRL_DIR];
						o_cmd.ms <= i_wb_dat[`CTRL_MS_LSB +: MW];
						o_cmd.xen <= i_wb_dat[`CTRL_XEN];
						o_cmd.xrst <= i_wb_dat[`CTRL_XRST];
					end
					WB_SPEED: o_cmd.speed <= i_wb_dat[VW-1:0];
					WB_STEPS: o_cmd.steps <= i_wb_dat[SW-1:0];
					WB_STROKE: o_cmd.stroke <= i_wb_dat[SW-1:0];
					WB_LIMITS: begin
						o_cmd.acce_max <= i_wb_dat[AW-1:0];
						o_cmd.deac_max <= i_wb_dat[`LIMITS_DEAC_LSB +: AW];
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req)
			o_wb_dat <= rd_data;
	end

	a_ack_single: assert property (@(posedge clk) disable iff (!resetn)
		o_wb_ack |=> !o_wb_ack);

endmodule

`default_nettype wire

// ==== verilog/step_motor_axis.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "motor_cfg.svh"

module step_motor_axis import motor_pkg::*; (
	input  wire                       clk,
	input  wire                       resetn,
	input  wire                       i_tick,
	input  wire motor_cmd_t           i_cmd,
	input  wire                       i_start,
	input  wire                       i_stop,
	input  wire                       i_zpd,
	input  wire [`MOTOR_SPEED_W-1:0]  i_acce_data,
	input  wire [`MOTOR_SPEED_W-1:0]  i_deac_data,
	output ramp_rd_t                  o_rd,
	output motor_status_t             o_status,
	output logic                      o_drive,
	output logic                      o_dir,
	output logic [`MOTOR_MS_W-1:0]    o_ms,
	output wire                       o_xen,
	output wire                       o_xrst
);
	localparam int SW = `MOTOR_STEP_W;
	localparam int VW = `MOTOR_SPEED_W;
	localparam int AW = `MOTOR_RAMP_AW;
	localparam int REV = `MOTOR_REV_DELAY;
	localparam int RW = (REV > 2) ? $clog2(REV - 1) : 1;

	motor_state_e state;
	logic start_d, stop_d, start_pend, stop_pend;
	logic is_idle, should_start, should_stop, high_end;
	logic step_done, rd_en, drive_d, drive_fall, tpsign;
	logic [5:1] rd_pipe;
	logic [RW-1:0] rev_cnt;
	logic [VW-1:0] speed_max, speed_var, speed_cur, speed_cnt;
	logic [SW-1:0] step_cnt, step_remain, fstep_cnt, fstep_remain;
	logic [SW-1:0] stroke_q, position, pos_next;
	logic [AW-1:0] acce_max_q, deac_max_q, acce_addr_q, deac_addr_q;

	assign is_idle = (state == IDLE);
	assign should_start = i_tick && start_pend && is_idle;
	assign high_end = (state == RUNNING) && (speed_cnt == '0) && o_drive;
	// dir 0 runs toward the stroke end, dir 1 toward zero
	assign should_stop = (step_done && speed_cnt == '0) || (tpsign && !o_dir) ||
		(i_zpd && o_dir);
	assign o_xen = i_cmd.xen;
	assign o_xrst = i_cmd.xrst;

	// edges held until the next tick
	always_ff @(posedge clk) begin
		if (!resetn) begin
			start_d <= 1'b0;
			stop_d <= 1'b0;
			start_pend <= 1'b0;
			stop_pend <= 1'b0;
		end else begin
			start_d <= i_start;
			stop_d <= i_stop;
			if (start_pend)
				start_pend <= !i_tick;
			else if (i_start && !start_d && is_idle)
				start_pend <= 1'b1;
			if (stop_pend)
				stop_pend <= !i_tick;
			else if (i_stop && !stop_d && !is_idle)
				stop_pend <= 1'b1;
		end
	end

	// move parameters held for the whole move
	always_ff @(posedge clk) begin
		if (should_start) begin
			speed_max <= i_cmd.speed;
			stroke_q <= i_cmd.stroke;
			acce_max_q <= i_cmd.acce_max;
			deac_max_q <= i_cmd.deac_max;
			o_ms <= i_cmd.ms;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			o_dir <= 1'b0;
		else if (should_start)
			o_dir <= i_cmd.dir;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= IDLE;
			rev_cnt <= '0;
		end else if (i_tick) begin
			case (state)
				IDLE: begin
					rev_cnt <= '0;
					if (start_pend)
						state <= (o_dir == i_cmd.dir) ? RUNNING : PREPARE;
				end
				PREPARE: begin
					rev_cnt <= rev_cnt + 1'b1;
					if (stop_pend)
						state <= IDLE;
					else if (rev_cnt == RW'(REV - 2))
						state <= RUNNING;
				end
				RUNNING: begin
					if (stop_pend || should_stop)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// done counts up, remaining counts down, one per drive pulse
	always_ff @(posedge clk) begin
		if (!resetn) begin
			step_cnt <= '0;
			step_remain <= '0;
			step_done <= 1'b0;
		end else if (i_tick) begin
			if (state != RUNNING)
				step_done <= 1'b0;
			else if (high_end && step_remain == '0)
				step_done <= 1'b1;
			if (should_start) begin
				step_cnt <= '0;
				step_remain <= i_cmd.steps - 1'b1;
			end else if (high_end) begin
				step_cnt <= step_cnt + 1'b1;
				step_remain <= step_remain - 1'b1;
			end
		end
	end

	// lookup launched at start and at the end of each high half
	always_ff @(posedge clk) begin
		if (!resetn) begin
			rd_en <= 1'b0;
			rd_pipe <= '0;
		end else begin
			rd_pipe <= {rd_pipe[4:1], rd_en};
			rd_en <= !rd_en && (should_start || (i_tick && high_end));
		end
	end

	always_ff @(posedge clk) begin
		if (rd_en) begin
			fstep_cnt <= step_cnt >> o_ms;
			fstep_remain <= step_remain >> o_ms;
		end
		if (rd_pipe[1]) begin
			acce_addr_q <= (fstep_cnt < SW'(acce_max_q)) ? fstep_cnt[AW-1:0] : acce_max_q;
			deac_addr_q <= (fstep_remain < SW'(deac_max_q)) ? fstep_remain[AW-1:0] : deac_max_q;
		end
		// table data lands two cycles after the read enable
		if (rd_pipe[4])
			speed_var <= (i_acce_data > i_deac_data) ? i_acce_data : i_deac_data;
	end

	// larger half-period means slower, so the max is the limit
	always_ff @(posedge clk) begin
		if (!resetn)
			speed_cur <= '0;
		else if (should_start)
			speed_cur <= i_cmd.speed;
		else if (rd_pipe[5])
			speed_cur <= (speed_var > speed_max) ? speed_var : speed_max;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			speed_cnt <= '0;
			o_drive <= 1'b0;
		end else if (i_tick) begin
			if (state != RUNNING || stop_pend || should_stop) begin
				speed_cnt <= '0;
				o_drive <= 1'b0;
			end else if (speed_cnt == '0) begin
				speed_cnt <= speed_cur;
				if (!step_done)
					o_drive <= !o_drive;
			end else begin
				speed_cnt <= speed_cnt - 1'b1;
			end
		end
	end

	// position moves on each falling drive edge
	assign drive_fall = drive_d && !o_drive;

	always_comb begin
		pos_next = position;
		if (!o_dir) begin
			if (position != stroke_q)
				pos_next = position + 1'b1;
		end else if (position > SW'(1)) begin
			pos_next = position - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			drive_d <= 1'b0;
			position <= SW'(1);
			tpsign <= 1'b0;
		end else begin
			drive_d <= o_drive;
			if (i_zpd) begin
				position <= SW'(1);
				tpsign <= 1'b0;
			end else if (drive_fall) begin
				position <= pos_next;
				tpsign <= (pos_next == stroke_q);
			end
		end
	end

	assign o_rd = '{en: rd_pipe[2], acce_addr: acce_addr_q, deac_addr: deac_addr_q};
	assign o_status = '{busy: !is_idle, zpsign: i_zpd, tpsign: tpsign, speed: speed_cur};

	if (REV < 2) begin : g_rev_check
		$error("reverse delay must be at least 2 ticks");
	end

	a_state_legal: assert property (@(posedge clk) disable iff (!resetn)
		state inside {IDLE, PREPARE, RUNNING});

	a_drive_quiet: assert property (@(posedge clk) disable iff (!resetn)
		(state != RUNNING) |-> !o_drive);

endmodule

`default_nettype wire

// ==== verilog/speed_ramp_ram.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "motor_cfg.svh"

module speed_ramp_ram import motor_pkg::*; (
	input  wire                       clk,
	input  wire ramp_wr_t             i_wr,
	input  wire ramp_rd_t             i_rd,
	output logic [`MOTOR_SPEED_W-1:0] o_acce_data,
	output logic [`MOTOR_SPEED_W-1:0] o_deac_data
);
	localparam int AW = `MOTOR_RAMP_AW;
	localparam int VW = `MOTOR_SPEED_W;
	localparam int DEPTH = 1 << AW;

	logic [VW-1:0] acce_mem [DEPTH];
	logic [VW-1:0] deac_mem [DEPTH];
	logic [AW-1:0] acce_addr_q;
	logic [AW-1:0] deac_addr_q;

	always_ff @(posedge clk) begin
		if (i_wr.en && !i_wr.sel)
			acce_mem[i_wr.addr] <= i_wr.data;
		if (i_wr.en && i_wr.sel)
			deac_mem[i_wr.addr] <= i_wr.data;
	end

	// address stage, then data stage
	always_ff @(posedge clk) begin
		if (i_rd.en) begin
			acce_addr_q <= i_rd.acce_addr;
			deac_addr_q <= i_rd.deac_addr;
		end
		o_acce_data <= acce_mem[acce_addr_q];
		o_deac_data <= deac_mem[deac_addr_q];
	end

	// host table loads must not collide with a core lookup
	a_no_rw_clash: assert property (@(posedge clk) (i_wr.en && i_rd.en) |->
		(i_wr.sel ? (i_wr.addr != i_rd.deac_addr) : (i_wr.addr != i_rd.acce_addr)));

endmodule

`default_nettype wire

// ==== verilog/step_tick_gen.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "motor_cfg.svh"

module step_tick_gen (
	input  wire  clk,
	input  wire  resetn,
	output logic o_tick
);
	localparam int DIV = `MOTOR_TICK_DIV;
	localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;
	localparam logic [CW-1:0] LAST = CW'(DIV - 1);

	logic [CW-1:0] cnt;

	// one tick per wrap of the divider
	always_ff @(posedge clk) begin
		if (!resetn) begin
			cnt <= '0;
			o_tick <= 1'b0;
		end else begin
			o_tick <= (cnt == LAST);
			if (cnt == LAST)
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/motor_pkg.sv ====
`default_nettype none
`include "motor_cfg.svh"

package motor_pkg;

	// bit 1 marks an active move
	typedef enum logic [1:0] {
		IDLE    = 2'b00,
		PREPARE = 2'b10,
		RUNNING = 2'b11
	} motor_state_e;

	typedef enum logic [2:0] {
		WB_CTRL   = `REG_CTRL,
		WB_SPEED  = `REG_SPEED,
		WB_STEPS  = `REG_STEPS,
		WB_STROKE = `REG_STROKE,
		WB_LIMITS = `REG_LIMITS,
		WB_STATUS = `REG_STATUS
	} wb_reg_e;

	typedef struct packed {
		logic [`MOTOR_SPEED_W-1:0] speed;
		logic [`MOTOR_STEP_W-1:0]  steps;
		logic [`MOTOR_STEP_W-1:0]  stroke;
		logic                      dir;
		logic [`MOTOR_MS_W-1:0]    ms;
		logic [`MOTOR_RAMP_AW-1:0] acce_max;
		logic [`MOTOR_RAMP_AW-1:0] deac_max;
		logic                      xen;
		logic                      xrst;
	} motor_cmd_t;

	typedef struct packed {
		logic                      busy;
		logic                      zpsign;
		logic                      tpsign;
		logic [`MOTOR_SPEED_W-1:0] speed;
	} motor_status_t;

	// sel high targets the deceleration table
	typedef struct packed {
		logic                      en;
		logic                      sel;
		logic [`MOTOR_RAMP_AW-1:0] addr;
		logic [`MOTOR_SPEED_W-1:0] data;
	} ramp_wr_t;

	typedef struct packed {
		logic                      en;
		logic [`MOTOR_RAMP_AW-1:0] acce_addr;
		logic [`MOTOR_RAMP_AW-1:0] deac_addr;
	} ramp_rd_t;

endpackage

`default_nettype wire

// ==== verilog/motor_cfg.svh ====
`ifndef MOTOR_CFG_SVH
`define MOTOR_CFG_SVH

// datapath widths
`define MOTOR_STEP_W    16
`define MOTOR_SPEED_W   16
`define MOTOR_RAMP_AW   9
`define MOTOR_MS_W      3
`define MOTOR_WB_AW     12
`define MOTOR_WB_DW     32

// settle ticks on a direction change, at least 2
`define MOTOR_REV_DELAY 4
// clk cycles per step tick
`define MOTOR_TICK_DIV  4

// register word offsets
`define REG_CTRL        0
`define REG_SPEED       1
`define REG_STEPS       2
`define REG_STROKE      3
`define REG_LIMITS      4
`define REG_STATUS      5
`define RAMP_BASE_ACC   'h200
`define RAMP_BASE_DEC   'h400

// CTRL bits
`define CTRL_START      0
`define CTRL_STOP       1
`define CTRL_DIR        2
`define CTRL_MS_LSB     4
`define CTRL_XEN        8
`define CTRL_XRST       9

// LIMITS and STATUS fields
`define LIMITS_DEAC_LSB 16
`define STATUS_BUSY     0
`define STATUS_ZPSIGN   1
`define STATUS_TPSIGN   2
`define STATUS_SPEED_LSB 16

`endif
